/* common/decode_pkg.sv */
package decode_pkg;

	localparam int INSTR_W = 32;
	localparam int REG_ADDR_W = 5;
	localparam int OP_W = 6;
	localparam int FUNCT_W = 6;

	// field positions in the instruction word
	localparam int OP_LSB = 26;
	localparam int RS_LSB = 21;
	localparam int RT_LSB = 16;
	localparam int RD_LSB = 11;
	localparam int SHAMT_LSB = 6;

	localparam logic [REG_ADDR_W-1:0] LINK_REG = 5'd31;

	// eret word in bits 25..0 with co set, zero fields and funct 0x18
	localparam logic [25:0] ERET_WORD = {5'h10, 15'd0, 6'h18};

	typedef enum logic [OP_W-1:0] {
		OP_R_TYPE = 6'h00,
		OP_REGIMM = 6'h01,
		OP_J      = 6'h02,
		OP_JAL    = 6'h03,
		OP_BEQ    = 6'h04,
		OP_BNE    = 6'h05,
		OP_BLEZ   = 6'h06,
		OP_BGTZ   = 6'h07,
		OP_ADDI   = 6'h08,
		OP_ADDIU  = 6'h09,
		OP_SLTI   = 6'h0a,
		OP_SLTIU  = 6'h0b,
		OP_ANDI   = 6'h0c,
		OP_ORI    = 6'h0d,
		OP_XORI   = 6'h0e,
		OP_LUI    = 6'h0f,
		OP_COP0   = 6'h10,
		OP_LB     = 6'h20,
		OP_LH     = 6'h21,
		OP_LW     = 6'h23,
		OP_LBU    = 6'h24,
		OP_LHU    = 6'h25,
		OP_SB     = 6'h28,
		OP_SH     = 6'h29,
		OP_SW     = 6'h2b
	} opcode_e;

	typedef enum logic [FUNCT_W-1:0] {
		FN_SLL     = 6'h00,
		FN_SRL     = 6'h02,
		FN_SRA     = 6'h03,
		FN_SLLV    = 6'h04,
		FN_SRLV    = 6'h06,
		FN_SRAV    = 6'h07,
		FN_JR      = 6'h08,
		FN_JALR    = 6'h09,
		FN_SYSCALL = 6'h0c,
		FN_BREAK   = 6'h0d,
		FN_MFHI    = 6'h10,
		FN_MTHI    = 6'h11,
		FN_MFLO    = 6'h12,
		FN_MTLO    = 6'h13,
		FN_MULT    = 6'h18,
		FN_MULTU   = 6'h19,
		FN_DIV     = 6'h1a,
		FN_DIVU    = 6'h1b,
		FN_ADD     = 6'h20,
		FN_ADDU    = 6'h21,
		FN_SUB     = 6'h22,
		FN_SUBU    = 6'h23,
		FN_AND     = 6'h24,
		FN_OR      = 6'h25,
		FN_XOR     = 6'h26,
		FN_NOR     = 6'h27,
		FN_SLT     = 6'h2a,
		FN_SLTU    = 6'h2b
	} funct_e;

	// rt field of regimm
	typedef enum logic [REG_ADDR_W-1:0] {
		RI_BLTZ   = 5'h00,
		RI_BGEZ   = 5'h01,
		RI_BLTZAL = 5'h10,
		RI_BGEZAL = 5'h11
	} regimm_e;

	// rs field of cop0
	typedef enum logic [REG_ADDR_W-1:0] {
		C0_MFC0 = 5'h00,
		C0_MTC0 = 5'h04,
		C0_CO   = 5'h10
	} cop0_e;

	typedef enum logic [4:0] {
		ALU_NONE, ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU,
		ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLL, ALU_SRL, ALU_SRA,
		ALU_LUI, ALU_MFC0, ALU_MTC0
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE = 3'd0,
		BR_EQ   = 3'd1,
		BR_NE   = 3'd2,
		BR_LEZ  = 3'd3,
		BR_GTZ  = 3'd4,
		BR_LTZ  = 3'd5,
		BR_GEZ  = 3'd6
	} branch_cond_e;

endpackage

/* decoder/ctrl_dec.sv */
`timescale 1ns/100ps

module ctrl_dec (
	input  decode_pkg::opcode_e                op,
	input  decode_pkg::funct_e                 funct,
	input  logic [decode_pkg::REG_ADDR_W-1:0]  rs,
	input  logic [decode_pkg::REG_ADDR_W-1:0]  rt,
	input  logic [decode_pkg::REG_ADDR_W-1:0]  rd,
	input  logic [decode_pkg::REG_ADDR_W-1:0]  shamt,
	input  logic                               instr_zero,
	output logic                               reg_write,
	output logic                               mem_to_reg,
	output logic                               mem_read,
	output logic                               mem_write,
	output logic                               is_imm,
	output logic [decode_pkg::REG_ADDR_W-1:0]  write_reg,
	output logic                               sign_ext,
	output logic                               reserved
);

	logic wr_raw, rd_mem_raw, wr_mem_raw;

	always_comb begin
		wr_raw = 1'b0;
		rd_mem_raw = 1'b0;
		wr_mem_raw = 1'b0;
		mem_to_reg = 1'b0;
		is_imm = 1'b0;
		write_reg = rd;
		reserved = 1'b0;
		case (op)
			decode_pkg::OP_R_TYPE: begin
				case (funct)
					decode_pkg::FN_ADD, decode_pkg::FN_ADDU, decode_pkg::FN_SUB,
					decode_pkg::FN_SUBU, decode_pkg::FN_SLT, decode_pkg::FN_SLTU,
					decode_pkg::FN_AND, decode_pkg::FN_OR, decode_pkg::FN_XOR,
					decode_pkg::FN_NOR, decode_pkg::FN_SLL, decode_pkg::FN_SRL,
					decode_pkg::FN_SRA, decode_pkg::FN_SLLV, decode_pkg::FN_SRLV,
					decode_pkg::FN_SRAV, decode_pkg::FN_MFHI, decode_pkg::FN_MFLO:
						wr_raw = 1'b1;
					decode_pkg::FN_JALR: begin
						wr_raw = 1'b1;
						write_reg = decode_pkg::LINK_REG;
					end
					decode_pkg::FN_JR, decode_pkg::FN_MTHI, decode_pkg::FN_MTLO,
					decode_pkg::FN_MULT, decode_pkg::FN_MULTU, decode_pkg::FN_DIV,
					decode_pkg::FN_DIVU, decode_pkg::FN_SYSCALL, decode_pkg::FN_BREAK: ;
					default: reserved = 1'b1;
				endcase
			end
			decode_pkg::OP_REGIMM: begin
				case (rt)
					decode_pkg::RI_BLTZAL, decode_pkg::RI_BGEZAL: begin
						wr_raw = 1'b1;
						write_reg = decode_pkg::LINK_REG;
					end
					decode_pkg::RI_BLTZ, decode_pkg::RI_BGEZ: ;
					default: reserved = 1'b1;
				endcase
			end
			decode_pkg::OP_J, decode_pkg::OP_BEQ, decode_pkg::OP_BNE,
			decode_pkg::OP_BLEZ, decode_pkg::OP_BGTZ: ;
			decode_pkg::OP_JAL: begin
				wr_raw = 1'b1;
				write_reg = decode_pkg::LINK_REG;
			end
			decode_pkg::OP_ADDI, decode_pkg::OP_ADDIU, decode_pkg::OP_SLTI,
			decode_pkg::OP_SLTIU, decode_pkg::OP_ANDI, decode_pkg::OP_ORI,
			decode_pkg::OP_XORI, decode_pkg::OP_LUI: begin
				wr_raw = 1'b1;
				is_imm = 1'b1;
				write_reg = rt;
			end
			decode_pkg::OP_LB, decode_pkg::OP_LH, decode_pkg::OP_LW,
			decode_pkg::OP_LBU, decode_pkg::OP_LHU: begin
				wr_raw = 1'b1;
				is_imm = 1'b1;
				write_reg = rt;
				mem_to_reg = 1'b1;
				rd_mem_raw = 1'b1;
			end
			decode_pkg::OP_SB, decode_pkg::OP_SH, decode_pkg::OP_SW: begin
				wr_mem_raw = 1'b1;
				is_imm = 1'b1;
			end
			decode_pkg::OP_COP0: begin
				case (rs)
					decode_pkg::C0_MFC0: begin
						wr_raw = 1'b1;
						write_reg = rt;
					end
					decode_pkg::C0_MTC0: ;
					// only the exact eret word is legal under co
					decode_pkg::C0_CO:
						reserved = ({rs, rt, rd, shamt, funct} != decode_pkg::ERET_WORD);
					default: reserved = 1'b1;
				endcase
			end
			default: reserved = 1'b1;
		endcase
	end

	// nop is sll r0 and writes nothing back
	assign reg_write = wr_raw & ~reserved & ~instr_zero;
	assign mem_read = rd_mem_raw & ~reserved;
	assign mem_write = wr_mem_raw & ~reserved;

	// andi, ori, xori, lui zero extend
	assign sign_ext = (op[5:2] != 4'b0011);

endmodule

/* decoder/alu_op_dec.sv */
`timescale 1ns/100ps

module alu_op_dec (
	input  decode_pkg::opcode_e                op,
	input  decode_pkg::funct_e                 funct,
	input  logic [decode_pkg::REG_ADDR_W-1:0]  rs,
	output decode_pkg::alu_op_e                alu_op
);

	always_comb begin
		alu_op = decode_pkg::ALU_NONE;
		case (op)
			decode_pkg::OP_R_TYPE: begin
				case (funct)
					decode_pkg::FN_ADD:  alu_op = decode_pkg::ALU_ADD;
					decode_pkg::FN_ADDU: alu_op = decode_pkg::ALU_ADDU;
					decode_pkg::FN_SUB:  alu_op = decode_pkg::ALU_SUB;
					decode_pkg::FN_SUBU: alu_op = decode_pkg::ALU_SUBU;
					decode_pkg::FN_SLT:  alu_op = decode_pkg::ALU_SLT;
					decode_pkg::FN_SLTU: alu_op = decode_pkg::ALU_SLTU;
					decode_pkg::FN_AND:  alu_op = decode_pkg::ALU_AND;
					decode_pkg::FN_OR:   alu_op = decode_pkg::ALU_OR;
					decode_pkg::FN_XOR:  alu_op = decode_pkg::ALU_XOR;
					decode_pkg::FN_NOR:  alu_op = decode_pkg::ALU_NOR;
					// variable shifts share the shifter op
					decode_pkg::FN_SLL, decode_pkg::FN_SLLV: alu_op = decode_pkg::ALU_SLL;
					decode_pkg::FN_SRL, decode_pkg::FN_SRLV: alu_op = decode_pkg::ALU_SRL;
					decode_pkg::FN_SRA, decode_pkg::FN_SRAV: alu_op = decode_pkg::ALU_SRA;
					default: alu_op = decode_pkg::ALU_NONE;
				endcase
			end
			decode_pkg::OP_ADDI:  alu_op = decode_pkg::ALU_ADD;
			decode_pkg::OP_ADDIU: alu_op = decode_pkg::ALU_ADDU;
			decode_pkg::OP_SLTI:  alu_op = decode_pkg::ALU_SLT;
			decode_pkg::OP_SLTIU: alu_op = decode_pkg::ALU_SLTU;
			decode_pkg::OP_ANDI:  alu_op = decode_pkg::ALU_AND;
			decode_pkg::OP_ORI:   alu_op = decode_pkg::ALU_OR;
			decode_pkg::OP_XORI:  alu_op = decode_pkg::ALU_XOR;
			decode_pkg::OP_LUI:   alu_op = decode_pkg::ALU_LUI;
			// address calc
			decode_pkg::OP_LB, decode_pkg::OP_LH, decode_pkg::OP_LW, decode_pkg::OP_LBU,
			decode_pkg::OP_LHU, decode_pkg::OP_SB, decode_pkg::OP_SH, decode_pkg::OP_SW:
				alu_op = decode_pkg::ALU_ADDU;
			decode_pkg::OP_COP0: begin
				if (rs == decode_pkg::C0_MFC0)
					alu_op = decode_pkg::ALU_MFC0;
				else if (rs == decode_pkg::C0_MTC0)
					alu_op = decode_pkg::ALU_MTC0;
			end
			default: alu_op = decode_pkg::ALU_NONE;
		endcase
	end

endmodule

/* decoder/operand_use_dec.sv */
`timescale 1ns/100ps

module operand_use_dec (
	input  decode_pkg::opcode_e                op,
	input  decode_pkg::funct_e                 funct,
	input  logic [decode_pkg::REG_ADDR_W-1:0]  rs,
	input  logic [decode_pkg::REG_ADDR_W-1:0]  rt,
	input  logic                               instr_zero,
	output logic                               read_rs,
	output logic                               read_rt,
	output decode_pkg::branch_cond_e           branch_cond
);

	always_comb begin
		read_rs = 1'b0;
		read_rt = 1'b0;
		case (op)
			decode_pkg::OP_R_TYPE: begin
				case (funct)
					decode_pkg::FN_ADD, decode_pkg::FN_ADDU, decode_pkg::FN_SUB,
					decode_pkg::FN_SUBU, decode_pkg::FN_SLT, decode_pkg::FN_SLTU,
					decode_pkg::FN_AND, decode_pkg::FN_OR, decode_pkg::FN_XOR,
					decode_pkg::FN_NOR, decode_pkg::FN_SLLV, decode_pkg::FN_SRLV,
					decode_pkg::FN_SRAV, decode_pkg::FN_MULT, decode_pkg::FN_MULTU,
					decode_pkg::FN_DIV, decode_pkg::FN_DIVU: begin
						read_rs = 1'b1;
						read_rt = 1'b1;
					end
					decode_pkg::FN_SLL, decode_pkg::FN_SRL, decode_pkg::FN_SRA:
						read_rt = 1'b1;
					decode_pkg::FN_JR, decode_pkg::FN_JALR, decode_pkg::FN_MTHI,
					decode_pkg::FN_MTLO:
						read_rs = 1'b1;
					default: ;
				endcase
			end
			decode_pkg::OP_BEQ, decode_pkg::OP_BNE,
			decode_pkg::OP_SB, decode_pkg::OP_SH, decode_pkg::OP_SW: begin
				read_rs = 1'b1;
				read_rt = 1'b1;
			end
			decode_pkg::OP_ADDI, decode_pkg::OP_ADDIU, decode_pkg::OP_SLTI,
			decode_pkg::OP_SLTIU, decode_pkg::OP_ANDI, decode_pkg::OP_ORI,
			decode_pkg::OP_XORI, decode_pkg::OP_BLEZ, decode_pkg::OP_BGTZ,
			decode_pkg::OP_LB, decode_pkg::OP_LH, decode_pkg::OP_LW,
			decode_pkg::OP_LBU, decode_pkg::OP_LHU:
				read_rs = 1'b1;
			decode_pkg::OP_REGIMM:
				read_rs = (rt == decode_pkg::RI_BLTZ) || (rt == decode_pkg::RI_BGEZ) ||
					(rt == decode_pkg::RI_BLTZAL) || (rt == decode_pkg::RI_BGEZAL);
			decode_pkg::OP_COP0:
				read_rt = (rs == decode_pkg::C0_MTC0);
			default: ;
		endcase
		// nop reads nothing
		if (instr_zero) begin
			read_rs = 1'b0;
			read_rt = 1'b0;
		end
	end

	always_comb begin
		case (op)
			decode_pkg::OP_BEQ:  branch_cond = decode_pkg::BR_EQ;
			decode_pkg::OP_BNE:  branch_cond = decode_pkg::BR_NE;
			decode_pkg::OP_BLEZ: branch_cond = decode_pkg::BR_LEZ;
			decode_pkg::OP_BGTZ: branch_cond = decode_pkg::BR_GTZ;
			decode_pkg::OP_REGIMM: begin
				case (rt)
					decode_pkg::RI_BLTZ, decode_pkg::RI_BLTZAL: branch_cond = decode_pkg::BR_LTZ;
					decode_pkg::RI_BGEZ, decode_pkg::RI_BGEZAL: branch_cond = decode_pkg::BR_GEZ;
					default: branch_cond = decode_pkg::BR_NONE;
				endcase
			end
			default: branch_cond = decode_pkg::BR_NONE;
		endcase
	end

endmodule

/* decoder/sys_dec.sv */
`timescale 1ns/100ps

module sys_dec (
	input  decode_pkg::opcode_e                op,
	input  decode_pkg::funct_e                 funct,
	input  logic [decode_pkg::REG_ADDR_W-1:0]  rs,
	output logic                               hilo_read,
	output logic                               hilo_write,
	output logic                               mul_div_en,
	output logic                               cp0_read,
	output logic                               cp0_write,
	output logic                               eret,
	output logic                               syscall,
	output logic                               brk
);

	logic is_special, is_cop0;

	assign is_special = (op == decode_pkg::OP_R_TYPE);
	assign is_cop0 = (op == decode_pkg::OP_COP0);

	// hi/lo moves
	assign hilo_read = is_special &&
		(funct == decode_pkg::FN_MFHI || funct == decode_pkg::FN_MFLO);
	assign hilo_write = is_special &&
		(funct == decode_pkg::FN_MTHI || funct == decode_pkg::FN_MTLO);

	always_comb begin
		mul_div_en = 1'b0;
		if (is_special) begin
			case (funct)
				decode_pkg::FN_MULT, decode_pkg::FN_MULTU,
				decode_pkg::FN_DIV, decode_pkg::FN_DIVU:
					mul_div_en = 1'b1;
				default: mul_div_en = 1'b0;
			endcase
		end
	end

	// cp0 ops keyed off rs
	assign cp0_read = is_cop0 && (rs == decode_pkg::C0_MFC0);
	assign cp0_write = is_cop0 && (rs == decode_pkg::C0_MTC0);
	assign eret = is_cop0 && (rs == decode_pkg::C0_CO);

	assign syscall = is_special && (funct == decode_pkg::FN_SYSCALL);
	assign brk = is_special && (funct == decode_pkg::FN_BREAK);

endmodule

/* hdl/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage (
	input  logic                                   clk,
	input  logic                                   rst_n,
	input  logic [decode_pkg::INSTR_W-1:0]         instr,
	input  logic                                   instr_valid,
	input  logic                                   stall,
	output logic                                   out_valid,
	output logic                                   reg_write,
	output logic                                   mem_to_reg,
	output logic                                   mem_read,
	output logic                                   mem_write,
	output logic                                   is_imm,
	output logic [decode_pkg::REG_ADDR_W-1:0]      write_reg,
	output logic                                   sign_ext,
	output decode_pkg::alu_op_e                    alu_op,
	output decode_pkg::branch_cond_e               branch_cond,
	output logic                                   read_rs,
	output logic                                   read_rt,
	output logic                                   hilo_read,
	output logic                                   hilo_write,
	output logic                                   mul_div_en,
	output logic                                   cp0_read,
	output logic                                   cp0_write,
	output logic                                   eret,
	output logic                                   syscall,
	output logic                                   brk,
	output logic                                   reserved
);

	decode_pkg::opcode_e op;
	decode_pkg::funct_e funct;
	logic [decode_pkg::REG_ADDR_W-1:0] rs, rt, rd, shamt;
	logic instr_zero;

	logic reg_write_d, mem_to_reg_d, mem_read_d, mem_write_d, is_imm_d;
	logic [decode_pkg::REG_ADDR_W-1:0] write_reg_d;
	logic sign_ext_d, reserved_d;
	decode_pkg::alu_op_e alu_op_d;
	decode_pkg::branch_cond_e branch_cond_d;
	logic read_rs_d, read_rt_d;
	logic hilo_read_d, hilo_write_d, mul_div_en_d;
	logic cp0_read_d, cp0_write_d, eret_d, syscall_d, brk_d;

	assign op = decode_pkg::opcode_e'(instr[decode_pkg::OP_LSB +: decode_pkg::OP_W]);
	assign funct = decode_pkg::funct_e'(instr[decode_pkg::FUNCT_W-1:0]);
	assign rs = instr[decode_pkg::RS_LSB +: decode_pkg::REG_ADDR_W];
	assign rt = instr[decode_pkg::RT_LSB +: decode_pkg::REG_ADDR_W];
	assign rd = instr[decode_pkg::RD_LSB +: decode_pkg::REG_ADDR_W];
	assign shamt = instr[decode_pkg::SHAMT_LSB +: decode_pkg::REG_ADDR_W];
	assign instr_zero = (instr == '0);

	ctrl_dec u_ctrl_dec (
		.op(op), .funct(funct), .rs(rs), .rt(rt), .rd(rd), .shamt(shamt),
		.instr_zero(instr_zero),
		.reg_write(reg_write_d), .mem_to_reg(mem_to_reg_d), .mem_read(mem_read_d),
		.mem_write(mem_write_d), .is_imm(is_imm_d), .write_reg(write_reg_d),
		.sign_ext(sign_ext_d), .reserved(reserved_d)
	);

	alu_op_dec u_alu_op_dec (.op(op), .funct(funct), .rs(rs), .alu_op(alu_op_d));

	operand_use_dec u_operand_use_dec (
		.op(op), .funct(funct), .rs(rs), .rt(rt), .instr_zero(instr_zero),
		.read_rs(read_rs_d), .read_rt(read_rt_d), .branch_cond(branch_cond_d)
	);

	sys_dec u_sys_dec (
		.op(op), .funct(funct), .rs(rs),
		.hilo_read(hilo_read_d), .hilo_write(hilo_write_d), .mul_div_en(mul_div_en_d),
		.cp0_read(cp0_read_d), .cp0_write(cp0_write_d), .eret(eret_d),
		.syscall(syscall_d), .brk(brk_d)
	);

	// a missing instruction loads a bubble into the stage register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			{reg_write, mem_to_reg, mem_read, mem_write, is_imm, sign_ext} <= '0;
			write_reg <= '0;
			alu_op <= decode_pkg::ALU_NONE;
			branch_cond <= decode_pkg::BR_NONE;
			{read_rs, read_rt, hilo_read, hilo_write, mul_div_en} <= '0;
			{cp0_read, cp0_write, eret, syscall, brk, reserved} <= '0;
		end else if (!stall) begin
			out_valid <= instr_valid;
			{reg_write, mem_to_reg, mem_read, mem_write, is_imm, sign_ext} <=
				{6{instr_valid}} &
				{reg_write_d, mem_to_reg_d, mem_read_d, mem_write_d, is_imm_d, sign_ext_d};
			write_reg <= instr_valid ? write_reg_d : '0;
			alu_op <= instr_valid ? alu_op_d : decode_pkg::ALU_NONE;
			branch_cond <= instr_valid ? branch_cond_d : decode_pkg::BR_NONE;
			{read_rs, read_rt, hilo_read, hilo_write, mul_div_en} <= {5{instr_valid}} &
				{read_rs_d, read_rt_d, hilo_read_d, hilo_write_d, mul_div_en_d};
			{cp0_read, cp0_write, eret, syscall, brk, reserved} <= {6{instr_valid}} &
				{cp0_read_d, cp0_write_d, eret_d, syscall_d, brk_d, reserved_d};
		end
	end

endmodule

/* dv/decode_stage_checker.sv */
`timescale 1ns/100ps

module decode_stage_checker (
	input logic                               clk,
	input logic                               rst_n,
	input logic                               stall,
	input logic                               out_valid,
	input logic                               reg_write,
	input logic                               mem_read,
	input logic                               mem_write,
	input logic [decode_pkg::REG_ADDR_W-1:0]  write_reg,
	input decode_pkg::alu_op_e                alu_op,
	input decode_pkg::branch_cond_e           branch_cond,
	input logic                               reserved
);

	logic any_write;
	logic [17:0] stage_view;

	assign any_write = reg_write || mem_read || mem_write;
	assign stage_view = {out_valid, reg_write, mem_read, mem_write, write_reg, alu_op,
		branch_cond, reserved};

	bubble_no_write: assert property (@(posedge clk) disable iff (!rst_n)
		!out_valid |-> !any_write)
		else $error("bubble carries a register or memory write");

	mem_strobes_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(mem_read && mem_write))
		else $error("mem_read and mem_write high together");

	// stage register holds its contents while stalled
	stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
		stall |=> $stable(stage_view))
		else $error("stage outputs changed during stall");

	reserved_no_write: assert property (@(posedge clk) disable iff (!rst_n)
		reserved |-> !any_write)
		else $error("reserved instruction carries a write");

endmodule

bind decode_stage decode_stage_checker u_decode_stage_checker (
	.clk(clk), .rst_n(rst_n), .stall(stall), .out_valid(out_valid),
	.reg_write(reg_write), .mem_read(mem_read), .mem_write(mem_write),
	.write_reg(write_reg), .alu_op(alu_op), .branch_cond(branch_cond),
	.reserved(reserved)
);

/* dv/decode_stage_tb.sv */
`timescale 1ns/100ps

module decode_stage_tb;

	localparam int RESET_CYCLES = 5;
	localparam int N_TESTS = 6;
	localparam int N_PER_TEST = 300;
	localparam int MAX_CYCLES = RESET_CYCLES + N_TESTS * (N_PER_TEST + 1) + 1 + 50;

	// table groups by index
	localparam int ALU_LO = 0;
	localparam int ALU_HI = 23;
	localparam int MBJ_LO = 24;
	localparam int MBJ_HI = 43;
	localparam int SYS_LO = 44;
	localparam int SYS_HI = 56;

	localparam logic [31:0] R_MASK = 32'h03FF_FFC0;
	localparam logic [31:0] I_MASK = 32'h03FF_FFFF;
	localparam logic [31:0] RI_MASK = 32'h03E0_FFFF;
	localparam logic [31:0] C0_MASK = 32'h001F_F800;

	localparam logic [5:0] ALU_FN [16] = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26,
		6'h27, 6'h2a, 6'h2b, 6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07};
	localparam logic [5:0] MEM_OP [8] = '{6'h20, 6'h21, 6'h23, 6'h24, 6'h25, 6'h28, 6'h29,
		6'h2b};
	localparam logic [5:0] SYS_FN [10] = '{6'h10, 6'h12, 6'h11, 6'h13, 6'h18, 6'h19, 6'h1a,
		6'h1b, 6'h0c, 6'h0d};

	typedef struct packed {
		logic out_valid;
		logic reg_write;
		logic mem_to_reg;
		logic mem_read;
		logic mem_write;
		logic is_imm;
		logic [4:0] write_reg;
		logic sign_ext;
		logic [4:0] alu_op;
		logic [2:0] branch_cond;
		logic read_rs;
		logic read_rt;
		logic hilo_read;
		logic hilo_write;
		logic mul_div_en;
		logic cp0_read;
		logic cp0_write;
		logic eret;
		logic syscall;
		logic brk;
		logic reserved;
	} outs_t;

	logic clk;
	logic rst_n;
	logic [31:0] instr;
	logic instr_valid;
	logic stall;
	logic out_valid, reg_write, mem_to_reg, mem_read, mem_write, is_imm;
	logic [4:0] write_reg;
	logic sign_ext;
	decode_pkg::alu_op_e alu_op;
	decode_pkg::branch_cond_e branch_cond;
	logic read_rs, read_rt, hilo_read, hilo_write, mul_div_en;
	logic cp0_read, cp0_write, eret, syscall, brk, reserved;

	integer seed;
	int err_count;
	int check_count;
	int tests_run;
	logic [31:0] tmpl [$];
	logic [31:0] rmask [$];
	outs_t exp_q [$];
	logic [31:0] word_q [$];
	outs_t held;
	logic [31:0] held_word;

	decode_stage DUT (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		int cycles;
		cycles = 0;
		while (cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

	task automatic add_enc(input logic [31:0] t, input logic [31:0] m);
		tmpl.push_back(t);
		rmask.push_back(m);
	endtask

	task automatic build_table();
		logic [5:0] op;
		logic [4:0] rt;
		foreach (ALU_FN[i])
			add_enc({26'd0, ALU_FN[i]}, R_MASK);
		for (int k = 8; k < 16; k++) begin
			op = k[5:0];
			add_enc({op, 26'd0}, I_MASK);
		end
		foreach (MEM_OP[i])
			add_enc({MEM_OP[i], 26'd0}, I_MASK);
		for (int k = 4; k < 8; k++) begin
			op = k[5:0];
			add_enc({op, 26'd0}, I_MASK);
		end
		// bltz, bgez, bltzal, bgezal
		for (int k = 0; k < 4; k++) begin
			rt = {k[1], 3'd0, k[0]};
			add_enc({6'h01, 5'd0, rt, 16'd0}, RI_MASK);
		end
		add_enc({6'h02, 26'd0}, I_MASK);
		add_enc({6'h03, 26'd0}, I_MASK);
		add_enc({26'd0, 6'h08}, R_MASK);
		add_enc({26'd0, 6'h09}, R_MASK);
		foreach (SYS_FN[i])
			add_enc({26'd0, SYS_FN[i]}, R_MASK);
		add_enc({6'h10, 5'h00, 21'd0}, C0_MASK);
		add_enc({6'h10, 5'h04, 21'd0}, C0_MASK);
		add_enc({6'h10, 26'h200_0018}, 32'd0);
	endtask

	function automatic logic [4:0] alu_of_funct(input logic [5:0] fn);
		case (fn)
			6'h20: return decode_pkg::ALU_ADD;
			6'h21: return decode_pkg::ALU_ADDU;
			6'h22: return decode_pkg::ALU_SUB;
			6'h23: return decode_pkg::ALU_SUBU;
			6'h24: return decode_pkg::ALU_AND;
			6'h25: return decode_pkg::ALU_OR;
			6'h26: return decode_pkg::ALU_XOR;
			6'h27: return decode_pkg::ALU_NOR;
			6'h2a: return decode_pkg::ALU_SLT;
			6'h2b: return decode_pkg::ALU_SLTU;
			6'h00, 6'h04: return decode_pkg::ALU_SLL;
			6'h02, 6'h06: return decode_pkg::ALU_SRL;
			default: return decode_pkg::ALU_SRA;
		endcase
	endfunction

	// expected stage outputs for one word
	function automatic outs_t model(input logic [31:0] w, input logic v);
		outs_t e;
		logic [5:0] op;
		logic [5:0] fn;
		logic [4:0] rs;
		logic [4:0] rt;
		logic wr;
		e = '0;
		op = w[31:26];
		fn = w[5:0];
		rs = w[25:21];
		rt = w[20:16];
		wr = 1'b0;
		if (!v)
			return e;
		e.out_valid = 1'b1;
		e.write_reg = w[15:11];
		// andi, ori, xori and lui zero extend
		e.sign_ext = !(op inside {6'h0c, 6'h0d, 6'h0e, 6'h0f});
		case (op)
			6'h00: begin
				case (fn)
					6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h20, 6'h21, 6'h22, 6'h23,
					6'h24, 6'h25, 6'h26, 6'h27, 6'h2a, 6'h2b: begin
						wr = 1'b1;
						e.alu_op = alu_of_funct(fn);
						e.read_rt = 1'b1;
						// constant shifts leave rs unread
						e.read_rs = fn[5] || fn[2];
					end
					6'h08: e.read_rs = 1'b1;
					6'h09: begin
						wr = 1'b1;
						e.read_rs = 1'b1;
						e.write_reg = 5'd31;
					end
					6'h0c: e.syscall = 1'b1;
					6'h0d: e.brk = 1'b1;
					6'h10, 6'h12: begin
						wr = 1'b1;
						e.hilo_read = 1'b1;
					end
					6'h11, 6'h13: begin
						e.read_rs = 1'b1;
						e.hilo_write = 1'b1;
					end
					6'h18, 6'h19, 6'h1a, 6'h1b: begin
						e.read_rs = 1'b1;
						e.read_rt = 1'b1;
						e.mul_div_en = 1'b1;
					end
					default: e.reserved = 1'b1;
				endcase
			end
			6'h01: begin
				if (rt inside {5'h00, 5'h01, 5'h10, 5'h11}) begin
					e.read_rs = 1'b1;
					e.branch_cond = rt[0] ? decode_pkg::BR_GEZ : decode_pkg::BR_LTZ;
					if (rt[4]) begin
						wr = 1'b1;
						e.write_reg = 5'd31;
					end
				end else begin
					e.reserved = 1'b1;
				end
			end
			6'h02: ;
			6'h03: begin
				wr = 1'b1;
				e.write_reg = 5'd31;
			end
			6'h04, 6'h05: begin
				e.read_rs = 1'b1;
				e.read_rt = 1'b1;
				e.branch_cond = op[0] ? decode_pkg::BR_NE : decode_pkg::BR_EQ;
			end
			6'h06, 6'h07: begin
				e.read_rs = 1'b1;
				e.branch_cond = op[0] ? decode_pkg::BR_GTZ : decode_pkg::BR_LEZ;
			end
			6'h08, 6'h09, 6'h0a, 6'h0b, 6'h0c, 6'h0d, 6'h0e, 6'h0f: begin
				wr = 1'b1;
				e.is_imm = 1'b1;
				e.write_reg = rt;
				e.read_rs = (op != 6'h0f);
				case (op[2:0])
					3'd0: e.alu_op = decode_pkg::ALU_ADD;
					3'd1: e.alu_op = decode_pkg::ALU_ADDU;
					3'd2: e.alu_op = decode_pkg::ALU_SLT;
					3'd3: e.alu_op = decode_pkg::ALU_SLTU;
					3'd4: e.alu_op = decode_pkg::ALU_AND;
					3'd5: e.alu_op = decode_pkg::ALU_OR;
					3'd6: e.alu_op = decode_pkg::ALU_XOR;
					default: e.alu_op = decode_pkg::ALU_LUI;
				endcase
			end
			6'h10: begin
				case (rs)
					5'h00: begin
						wr = 1'b1;
						e.write_reg = rt;
						e.cp0_read = 1'b1;
						e.alu_op = decode_pkg::ALU_MFC0;
					end
					5'h04: begin
						e.read_rt = 1'b1;
						e.cp0_write = 1'b1;
						e.alu_op = decode_pkg::ALU_MTC0;
					end
					5'h10: begin
						e.eret = 1'b1;
						e.reserved = (w[25:0] != 26'h200_0018);
					end
					default: e.reserved = 1'b1;
				endcase
			end
			6'h20, 6'h21, 6'h23, 6'h24, 6'h25: begin
				wr = 1'b1;
				e.is_imm = 1'b1;
				e.write_reg = rt;
				e.mem_to_reg = 1'b1;
				e.mem_read = 1'b1;
				e.read_rs = 1'b1;
				e.alu_op = decode_pkg::ALU_ADDU;
			end
			6'h28, 6'h29, 6'h2b: begin
				e.mem_write = 1'b1;
				e.is_imm = 1'b1;
				e.read_rs = 1'b1;
				e.read_rt = 1'b1;
				e.alu_op = decode_pkg::ALU_ADDU;
			end
			default: e.reserved = 1'b1;
		endcase
		// nop writes and reads nothing
		e.reg_write = wr && !e.reserved && (w != '0);
		if (w == '0) begin
			e.read_rs = 1'b0;
			e.read_rt = 1'b0;
		end
		return e;
	endfunction

	function automatic outs_t sample();
		return {out_valid, reg_write, mem_to_reg, mem_read, mem_write, is_imm, write_reg,
			sign_ext, alu_op, branch_cond, read_rs, read_rt, hilo_read, hilo_write,
			mul_div_en, cp0_read, cp0_write, eret, syscall, brk, reserved};
	endfunction

	function automatic logic coin();
		logic [31:0] r;
		r = $random(seed);
		return r[0];
	endfunction

	function automatic logic [31:0] table_word(input int lo, input int hi);
		int idx;
		logic [31:0] r;
		idx = lo + int'($unsigned($random(seed)) % (hi - lo + 1));
		r = $random(seed);
		return tmpl[idx] | (r & rmask[idx]);
	endfunction

	task automatic check_outputs();
		outs_t got;
		got = sample();
		held = exp_q.pop_front();
		held_word = word_q.pop_front();
		check_count++;
		assert (got == held) else begin
			err_count++;
			$display("Fail at %0t ns: instr %h gave outputs %h, expected %h",
				$time, held_word, got, held);
		end
	endtask

	task automatic drive_next(input int mode);
		logic [31:0] w;
		logic v;
		logic s;
		case (mode)
			1: w = table_word(ALU_LO, ALU_HI);
			2: w = table_word(MBJ_LO, MBJ_HI);
			3: w = table_word(SYS_LO, SYS_HI);
			4: w = $random(seed);
			default: w = coin() ? table_word(0, tmpl.size() - 1) : $random(seed);
		endcase
		v = (mode == 0) ? coin() : (($unsigned($random(seed)) % 8) != 0);
		s = (mode == 5) && (($unsigned($random(seed)) % 3) == 0);
		// upstream keeps presenting the stalled word
		if (stall) begin
			w = instr;
			v = instr_valid;
		end
		instr = w;
		instr_valid = v;
		stall = s;
		if (s) begin
			exp_q.push_back(held);
			word_q.push_back(held_word);
		end else begin
			exp_q.push_back(model(w, v));
			word_q.push_back(w);
		end
	endtask

	task automatic run_test(input string name, input int mode);
		int errs0;
		int checks0;
		errs0 = err_count;
		checks0 = check_count;
		for (int i = 0; i < N_PER_TEST; i++) begin
			@(negedge clk);
			check_outputs();
			drive_next(mode);
		end
		// bubble so the last result lands inside this test
		@(negedge clk);
		check_outputs();
		instr_valid = 1'b0;
		stall = 1'b0;
		exp_q.push_back('0);
		word_q.push_back(instr);
		tests_run++;
		$display("test %-16s %0d checks, %0d errors", name, check_count - checks0,
			err_count - errs0);
	endtask

	initial begin
		seed = 5;
		err_count = 0;
		check_count = 0;
		tests_run = 0;
		instr = '0;
		instr_valid = 1'b0;
		stall = 1'b0;
		rst_n = 1'b0;
		build_table();
		repeat (RESET_CYCLES) @(negedge clk);
		assert (sample() == '0) else begin
			err_count++;
			$display("Fail at %0t ns: outputs %h not in bubble state during reset",
				$time, sample());
		end
		rst_n = 1'b1;
		exp_q.push_back('0);
		word_q.push_back('0);
		run_test("reset_bubbles", 0);
		run_test("alu_reg_ctrl", 1);
		run_test("mem_branch_jump", 2);
		run_test("system_flags", 3);
		run_test("reserved", 4);
		run_test("stall", 5);
		@(negedge clk);
		check_outputs();
		$display("tests %0d, checks %0d, errors %0d", tests_run, check_count, err_count);
		if (err_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

/* list.f */
common/decode_pkg.sv
decoder/ctrl_dec.sv
decoder/alu_op_dec.sv
decoder/operand_use_dec.sv
decoder/sys_dec.sv
hdl/decode_stage.sv
dv/decode_stage_checker.sv
dv/decode_stage_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = decode_stage_tb
FILELIST = list.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG) || ! grep -q "STATUS: PASS" $(LOG); then \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
